// ==== hw/mv_defines.svh ====
`ifndef MV_DEFINES_SVH
`define MV_DEFINES_SVH

// Matrix dimensions, powers of two so indices cannot overrun
`define MV_ROWS 4
`define MV_COLS 4

// Element width for A and x
`define MV_ELEM_W 8

// Accumulator and result width, sums wrap at this size
`define MV_ACC_W 32

`endif

// ==== hw/mv_data_pkg.sv ====
`include "mv_defines.svh"

package mv_data_pkg;

  // Operand and result payloads
  typedef logic [`MV_ELEM_W-1:0] elem_t;
  typedef logic [`MV_ACC_W-1:0]  acc_t;

  // Indices into A, x and y
  typedef logic [$clog2(`MV_ROWS)-1:0] row_idx_t;
  typedef logic [$clog2(`MV_COLS)-1:0] col_idx_t;

  // Memory targeted by a host write
  typedef enum logic {
    MEM_A = 1'b0,
    MEM_X = 1'b1
  } mem_sel_t;

  // Host write request, row is ignored for MEM_X
  typedef struct packed {
    logic     write;
    mem_sel_t sel;
    row_idx_t row;
    col_idx_t col;
    elem_t    wdata;
  } host_wr_t;

endpackage

// ==== hw/mv_ctrl_pkg.sv ====
package mv_ctrl_pkg;

  // Kernel sequencing states
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    CLEAR = 3'd1,
    READ  = 3'd2,
    MAC   = 3'd3,
    WRITE = 3'd4,
    DONE  = 3'd5
  } kernel_state_t;

  // Index counter command from the FSM
  typedef struct packed {
    logic clear;
    logic col_step;
    logic row_step;
  } cnt_cmd_t;

endpackage

// ==== hw/comb_mem.sv ====
`timescale 1ns/1ps

module comb_mem
  import mv_data_pkg::*;
#(
  parameter type word_t = elem_t,
  parameter int  DEPTH  = 4,
  parameter int  ADDR_W = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] addr,
  input  logic              write_en,
  input  word_t             write_data,
  output word_t             read_data,
  output logic              done
);

  word_t mem [DEPTH];

  // Zero-latency read port
  assign read_data = mem[addr];

  // Write completion, one cycle behind the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= write_en;
    end
  end

  // Contents clear on reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (write_en) begin
      mem[addr] <= write_data;
    end
  end

endmodule

// ==== hw/seq_mem_d2.sv ====
`timescale 1ns/1ps

module seq_mem_d2
  import mv_data_pkg::*;
#(
  parameter int D0_SIZE = 4,
  parameter int D1_SIZE = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  row_idx_t addr0,
  input  col_idx_t addr1,
  input  logic     content_en,
  input  logic     write_en,
  input  elem_t    write_data,
  output elem_t    read_data,
  output logic     done
);

  localparam int DEPTH  = D0_SIZE * D1_SIZE;
  localparam int ADDR_W = $clog2(DEPTH);

  elem_t             mem [DEPTH];
  logic [ADDR_W-1:0] flat_addr;

  // Row-major flattening
  assign flat_addr = ADDR_W'(addr0) * ADDR_W'(D1_SIZE) + ADDR_W'(addr1);

  always_ff @(posedge clk) begin
    if (reset) begin
      read_data <= '0;
    end else if (content_en && !write_en) begin
      read_data <= mem[flat_addr];
    end else if (content_en && write_en) begin
      // Read port is undefined after a write
      read_data <= 'x;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= content_en;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset && content_en && write_en) begin
      mem[flat_addr] <= write_data;
    end
  end

endmodule

// ==== hw/mv_index_counter.sv ====
`timescale 1ns/1ps

module mv_index_counter
  import mv_data_pkg::*;
  import mv_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  cnt_cmd_t cmd,
  output row_idx_t row,
  output col_idx_t col,
  output logic     col_last,
  output logic     row_last
);

  // Dimensions are powers of two, so the last index is all ones
  assign col_last = (col == '1);
  assign row_last = (row == '1);

  always_ff @(posedge clk) begin
    if (reset || cmd.clear) begin
      col <= '0;
    end else if (cmd.col_step) begin
      col <= col_last ? '0 : col + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || cmd.clear) begin
      row <= '0;
    end else if (cmd.row_step) begin
      row <= row_last ? '0 : row + 1'b1;
    end
  end

endmodule

// ==== hw/mv_control_fsm.sv ====
`timescale 1ns/1ps

module mv_control_fsm
  import mv_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     go,
  input  logic     col_last,
  input  logic     row_last,
  output cnt_cmd_t cnt_cmd,
  output logic     a_content_en,
  output logic     acc_clear,
  output logic     acc_en,
  output logic     y_write_en,
  output logic     busy,
  output logic     done
);

  kernel_state_t state;
  kernel_state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // One row costs CLEAR, then READ/MAC per column, then WRITE
  always_comb begin
    state_next = state;
    unique case (state)
      IDLE:    if (go) state_next = CLEAR;
      CLEAR:   state_next = READ;
      READ:    state_next = MAC;
      MAC:     state_next = col_last ? WRITE : READ;
      WRITE:   state_next = row_last ? DONE : CLEAR;
      DONE:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // Moore outputs
  assign a_content_en     = (state == READ);
  assign acc_clear        = (state == CLEAR);
  assign acc_en           = (state == MAC);
  assign y_write_en       = (state == WRITE);
  assign busy             = (state != IDLE);
  assign done             = (state == DONE);

  // Indices restart while idle, col steps after each MAC, row after WRITE
  assign cnt_cmd.clear    = (state == IDLE);
  assign cnt_cmd.col_step = (state == MAC);
  assign cnt_cmd.row_step = (state == WRITE);

endmodule

// ==== hw/mv_mac.sv ====
`timescale 1ns/1ps

module mv_mac
  import mv_data_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  acc_clear,
  input  logic  acc_en,
  input  elem_t a_data,
  input  elem_t x_data,
  output acc_t  acc
);

  acc_t product;

  // Unsigned product, widened before the multiply
  assign product = acc_t'(a_data) * acc_t'(x_data);

  always_ff @(posedge clk) begin
    if (reset || acc_clear) begin
      acc <= '0;
    end else if (acc_en) begin
      // Wraps modulo 2**MV_ACC_W
      acc <= acc + product;
    end
  end

endmodule

// ==== hw/mv_kernel_top.sv ====
`timescale 1ns/1ps

`include "mv_defines.svh"

module mv_kernel_top
  import mv_data_pkg::*;
  import mv_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     go,
  input  host_wr_t host_wr,
  input  row_idx_t y_addr,
  output acc_t     y_rdata,
  output logic     busy,
  output logic     done
);

  cnt_cmd_t cnt_cmd;
  row_idx_t row;
  col_idx_t col;
  logic     col_last;
  logic     row_last;
  logic     a_content_en;
  logic     acc_clear;
  logic     acc_en;
  logic     y_write_en;
  acc_t     acc;

  logic     host_a_wr;
  logic     host_x_wr;
  row_idx_t a_row;
  col_idx_t a_col;
  logic     a_mem_en;
  elem_t    a_rdata;
  col_idx_t x_addr;
  elem_t    x_rdata;
  row_idx_t y_mem_addr;

  // Host writes only land while the kernel is idle
  assign host_a_wr  = !busy && host_wr.write && (host_wr.sel == MEM_A);
  assign host_x_wr  = !busy && host_wr.write && (host_wr.sel == MEM_X);

  assign a_row      = busy ? row : host_wr.row;
  assign a_col      = busy ? col : host_wr.col;
  assign a_mem_en   = busy ? a_content_en : host_a_wr;
  assign x_addr     = busy ? col : host_wr.col;
  assign y_mem_addr = busy ? row : y_addr;

  mv_control_fsm i_mv_control_fsm (
    .clk          (clk),
    .reset        (reset),
    .go           (go),
    .col_last     (col_last),
    .row_last     (row_last),
    .cnt_cmd      (cnt_cmd),
    .a_content_en (a_content_en),
    .acc_clear    (acc_clear),
    .acc_en       (acc_en),
    .y_write_en   (y_write_en),
    .busy         (busy),
    .done         (done)
  );

  mv_index_counter i_mv_index_counter (
    .clk      (clk),
    .reset    (reset),
    .cmd      (cnt_cmd),
    .row      (row),
    .col      (col),
    .col_last (col_last),
    .row_last (row_last)
  );

  seq_mem_d2 #(
    .D0_SIZE (`MV_ROWS),
    .D1_SIZE (`MV_COLS)
  ) i_a_mem (
    .clk        (clk),
    .reset      (reset),
    .addr0      (a_row),
    .addr1      (a_col),
    .content_en (a_mem_en),
    .write_en   (host_a_wr),
    .write_data (host_wr.wdata),
    .read_data  (a_rdata),
    .done       ()
  );

  comb_mem #(
    .word_t (elem_t),
    .DEPTH  (`MV_COLS)
  ) i_x_mem (
    .clk        (clk),
    .reset      (reset),
    .addr       (x_addr),
    .write_en   (host_x_wr),
    .write_data (host_wr.wdata),
    .read_data  (x_rdata),
    .done       ()
  );

  // A data is registered from READ, x is read live in MAC
  mv_mac i_mv_mac (
    .clk       (clk),
    .reset     (reset),
    .acc_clear (acc_clear),
    .acc_en    (acc_en),
    .a_data    (a_rdata),
    .x_data    (x_rdata),
    .acc       (acc)
  );

  comb_mem #(
    .word_t (acc_t),
    .DEPTH  (`MV_ROWS)
  ) i_y_mem (
    .clk        (clk),
    .reset      (reset),
    .addr       (y_mem_addr),
    .write_en   (y_write_en),
    .write_data (acc),
    .read_data  (y_rdata),
    .done       ()
  );

endmodule

// ==== testbench/mv_kernel_sva.sv ====
`timescale 1ns/1ps

module mv_kernel_sva
  import mv_data_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     busy,
  input logic     done,
  input host_wr_t host_wr,
  input logic     a_write_en
);

  // done is a single-cycle pulse
  done_one_cycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  // DONE always returns to IDLE
  busy_falls_after_done: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
    else $error("busy still high the cycle after done");

  // Host requests for A during a run never reach the memory
  no_a_write_while_busy: assert property (@(posedge clk) disable iff (reset)
    busy && host_wr.write && (host_wr.sel == MEM_A) |-> !a_write_en)
    else $error("host write reached the A memory while busy");

endmodule

bind mv_kernel_top mv_kernel_sva i_mv_kernel_sva (
  .clk        (clk),
  .reset      (reset),
  .busy       (busy),
  .done       (done),
  .host_wr    (host_wr),
  .a_write_en (host_a_wr)
);

// ==== testbench/mv_kernel_tb.sv ====
`timescale 1ns/1ps

`include "mv_defines.svh"

module mv_kernel_tb
  import mv_data_pkg::*;
();

  localparam int ROWS          = `MV_ROWS;
  localparam int COLS          = `MV_COLS;
  localparam int CLK_PERIOD    = 100;
  localparam int RUN_CYCLES    = ROWS * (2 * COLS + 2);
  localparam int DONE_TIMEOUT  = 4 * RUN_CYCLES;

  logic     clk;
  logic     reset;
  logic     go;
  host_wr_t host_wr;
  row_idx_t y_addr;
  acc_t     y_rdata;
  logic     busy;
  logic     done;

  // Host-side copies of the loaded A and x
  elem_t       a_model [ROWS][COLS];
  elem_t       x_model [COLS];
  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] lcg_state;

  mv_kernel_top i_mv_kernel_top (
    .clk     (clk),
    .reset   (reset),
    .go      (go),
    .host_wr (host_wr),
    .y_addr  (y_addr),
    .y_rdata (y_rdata),
    .busy    (busy),
    .done    (done)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic elem_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Dot product of one row, wrapping at 32 bits
  function automatic acc_t expected_y(input int row);
    acc_t sum;
    sum = '0;
    for (int j = 0; j < COLS; j++) begin
      sum = sum + acc_t'(a_model[row][j]) * acc_t'(x_model[j]);
    end
    return sum;
  endfunction

  task automatic host_write(input mem_sel_t sel, input int row, input int col, input elem_t value);
    @(negedge clk);
    host_wr.write = 1'b1;
    host_wr.sel   = sel;
    host_wr.row   = row_idx_t'(row);
    host_wr.col   = col_idx_t'(col);
    host_wr.wdata = value;
    @(negedge clk);
    host_wr = '0;
  endtask

  task automatic write_a(input int row, input int col, input elem_t value);
    host_write(MEM_A, row, col, value);
    a_model[row][col] = value;
  endtask

  task automatic write_x(input int col, input elem_t value);
    host_write(MEM_X, 0, col, value);
    x_model[col] = value;
  endtask

  // Write that must be dropped because the kernel is running
  task automatic issue_blocked_write(input int step);
    host_wr.write = 1'b1;
    host_wr.sel   = step[0] ? MEM_X : MEM_A;
    host_wr.row   = row_idx_t'(next_rand());
    host_wr.col   = col_idx_t'(next_rand());
    host_wr.wdata = next_rand();
  endtask

  task automatic run_kernel(input bit host_noise, output int run_cycles);
    int  waited;
    bit  seen_done;
    waited = 0;
    seen_done = 1'b0;
    @(negedge clk);
    go = 1'b1;
    while (!seen_done && waited < DONE_TIMEOUT) begin
      @(negedge clk);
      go = 1'b0;
      waited++;
      checks++;
      assert (busy) else begin
        errors++;
        $display("[ERROR] %0t: busy low while waiting for done", $time);
      end
      if (done) begin
        seen_done = 1'b1;
        host_wr = '0;
      end else if (host_noise) begin
        issue_blocked_write(waited);
      end
    end
    if (!seen_done) begin
      errors++;
      $display("Timeout: done did not arrive within %0d cycles of go", DONE_TIMEOUT);
    end
    // First counted edge is the one that samples go
    run_cycles = waited - 1;
  endtask

  task automatic check_y(input string tag);
    acc_t expected;
    for (int i = 0; i < ROWS; i++) begin
      @(negedge clk);
      y_addr = row_idx_t'(i);
      expected = expected_y(i);
      // Combinational read, data is due within the same cycle
      #(CLK_PERIOD / 4);
      checks++;
      assert (y_rdata === expected) else begin
        errors++;
        $display("[ERROR] %0t: %s y[%0d] = %0h, expected %0h",
                 $time, tag, i, y_rdata, expected);
      end
    end
  endtask

  task automatic load_random();
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        write_a(i, j, next_rand());
      end
    end
    for (int j = 0; j < COLS; j++) begin
      write_x(j, next_rand());
    end
  endtask

  task automatic reset_defaults();
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        a_model[i][j] = '0;
      end
    end
    for (int j = 0; j < COLS; j++) begin
      x_model[j] = '0;
    end
    checks++;
    assert (!busy && !done) else begin
      errors++;
      $display("[ERROR] %0t: busy=%b done=%b after reset", $time, busy, done);
    end
    check_y("reset");
  endtask

  task automatic identity_passthrough();
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        write_a(i, j, (i == j) ? elem_t'(1) : elem_t'(0));
      end
    end
    for (int j = 0; j < COLS; j++) begin
      write_x(j, next_rand());
    end
    run_kernel(1'b0, cycles);
    check_y("identity");
  endtask

  task automatic random_with_timing();
    load_random();
    run_kernel(1'b0, cycles);
    checks++;
    assert (cycles == RUN_CYCLES) else begin
      errors++;
      $display("[ERROR] %0t: done after %0d cycles, expected %0d", $time, cycles, RUN_CYCLES);
    end
    check_y("random");
  endtask

  task automatic full_scale_and_new_x();
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        write_a(i, j, 8'hff);
      end
    end
    for (int j = 0; j < COLS; j++) begin
      write_x(j, 8'hff);
    end
    run_kernel(1'b0, cycles);
    check_y("full scale");
    // Same A, fresh x
    for (int j = 0; j < COLS; j++) begin
      write_x(j, next_rand());
    end
    run_kernel(1'b0, cycles);
    check_y("new x");
  endtask

  task automatic writes_while_busy();
    load_random();
    run_kernel(1'b1, cycles);
    check_y("writes while busy");
    run_kernel(1'b0, cycles);
    check_y("rerun after blocked writes");
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    go        = 1'b0;
    host_wr   = '0;
    y_addr    = '0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    lcg_state = 32'd18171;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    reset_defaults();
    identity_passthrough();
    random_with_timing();
    full_scale_and_new_x();
    writes_while_busy();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+hw
hw/mv_data_pkg.sv
hw/mv_ctrl_pkg.sv
hw/comb_mem.sv
hw/seq_mem_d2.sv
hw/mv_index_counter.sv
hw/mv_control_fsm.sv
hw/mv_mac.sv
hw/mv_kernel_top.sv
testbench/mv_kernel_sva.sv
testbench/mv_kernel_tb.sv

// ==== Makefile ====
# Verilator simulation of the matrix-vector kernel

VERILATOR  ?= verilator
TOP        ?= mv_kernel_tb
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing --assert
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
